// File: logic/ex_consts.svh
// Width and count macros for the execute slice, included by the RTL and the testbench.
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Data and address width in bits.
`define DATA_WIDTH 32

// Width of a register index.
`define REG_ADDR_WIDTH 5

// Architectural registers, x0 included.
`define REG_COUNT 32

`endif

// File: logic/ex_stage_pkg.sv
// Operation encodings shared by the execute stage, its units and the testbench.
package ex_stage_pkg;

    // ALU operation.
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10  // lui
    } aluop_t;

    // Branch condition.
    typedef enum logic [2:0] {
        cfu_none = 3'd0,
        cfu_beq  = 3'd1,
        cfu_bne  = 3'd2,
        cfu_blt  = 3'd3,
        cfu_bge  = 3'd4,
        cfu_bltu = 3'd5,
        cfu_bgeu = 3'd6,
        cfu_jump = 3'd7   // Always taken.
    } cfuop_t;

    // Writeback source.
    typedef enum logic {
        wb_alu = 1'b0,
        wb_pc4 = 1'b1
    } wb_sel_t;

endpackage : ex_stage_pkg

// File: logic/fu.sv
// Forwarding unit of the execute stage; picks the newest source for each register operand.
`timescale 1ns/10ps
`include "ex_consts.svh"

// Select codes on for_a and for_b:
//   2'b00  register file value captured at issue
//   2'b01  result held in the memory stage
//   2'b10  data held in the writeback stage
module fu (
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    input  logic                       mem_rf_en,
    input  logic [`REG_ADDR_WIDTH-1:0] mem_rd,
    input  logic                       wb_rf_en,
    input  logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [1:0]                 for_a,
    output logic [1:0]                 for_b
);

    localparam logic [1:0] for_rf  = 2'b00;
    localparam logic [1:0] for_mem = 2'b01;
    localparam logic [1:0] for_wb  = 2'b10;

    function automatic logic [1:0] pick_src(input logic [`REG_ADDR_WIDTH-1:0] rs);
        logic [1:0] src;
        src = for_rf;
        if (rs != '0)
        begin
            if (mem_rf_en && (mem_rd == rs))
                src = for_mem;          // Youngest producer wins.
            else if (wb_rf_en && (wb_rd == rs))
                src = for_wb;
        end
        return src;
    endfunction

    assign for_a = pick_src(rs1);
    assign for_b = pick_src(rs2);

endmodule : fu

// File: logic/alu.sv
// RV32I integer ALU used by the execute stage for results and branch targets.
`timescale 1ns/10ps
`include "ex_consts.svh"

module alu (
    input  ex_stage_pkg::aluop_t   aluop,
    input  logic [`DATA_WIDTH-1:0] opr_a,
    input  logic [`DATA_WIDTH-1:0] opr_b,
    output logic [`DATA_WIDTH-1:0] opr_result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = opr_b[4:0];                          // Low five bits only.
    assign lt_signed   = $signed(opr_a) < $signed(opr_b);
    assign lt_unsigned = opr_a < opr_b;

    always_comb
    begin
        case (aluop)
            ex_stage_pkg::alu_add:
                opr_result = opr_a + opr_b;
            ex_stage_pkg::alu_sub:
                opr_result = opr_a - opr_b;
            ex_stage_pkg::alu_sll:
                opr_result = opr_a << shamt;
            ex_stage_pkg::alu_slt:
                opr_result = {{(`DATA_WIDTH-1){1'b0}}, lt_signed};
            ex_stage_pkg::alu_sltu:
                opr_result = {{(`DATA_WIDTH-1){1'b0}}, lt_unsigned};
            ex_stage_pkg::alu_xor:
                opr_result = opr_a ^ opr_b;
            ex_stage_pkg::alu_srl:
                opr_result = opr_a >> shamt;
            ex_stage_pkg::alu_sra:
                opr_result = $unsigned($signed(opr_a) >>> shamt);  // Sign fill.
            ex_stage_pkg::alu_or:
                opr_result = opr_a | opr_b;
            ex_stage_pkg::alu_and:
                opr_result = opr_a & opr_b;
            ex_stage_pkg::alu_pass_b:
                opr_result = opr_b;
            default:
                opr_result = '0;
        endcase
    end

endmodule : alu

// File: logic/cfu.sv
// Branch condition evaluator of the execute stage, fed with the forwarded register operands.
`timescale 1ns/10ps
`include "ex_consts.svh"

module cfu (
    input  ex_stage_pkg::cfuop_t   cfuop,
    input  logic [`DATA_WIDTH-1:0] opr_a,
    input  logic [`DATA_WIDTH-1:0] opr_b,
    output logic                   br_taken
);

    logic eq;
    logic lt_signed;
    logic lt_unsigned;

    assign eq          = opr_a == opr_b;
    assign lt_signed   = $signed(opr_a) < $signed(opr_b);
    assign lt_unsigned = opr_a < opr_b;

    always_comb
    begin
        case (cfuop)
            ex_stage_pkg::cfu_beq:  br_taken = eq;
            ex_stage_pkg::cfu_bne:  br_taken = !eq;
            ex_stage_pkg::cfu_blt:  br_taken = lt_signed;
            ex_stage_pkg::cfu_bge:  br_taken = !lt_signed;
            ex_stage_pkg::cfu_bltu: br_taken = lt_unsigned;
            ex_stage_pkg::cfu_bgeu: br_taken = !lt_unsigned;
            ex_stage_pkg::cfu_jump: br_taken = 1'b1;
            default:                br_taken = 1'b0;  // No branch.
        endcase
    end

endmodule : cfu

// File: logic/ex_stage.sv
// Execute stage with forwarding, operand select, ALU and CFU, ending in the EX/MEM register.
`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       valid,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    input  logic [`DATA_WIDTH-1:0]     rs1_data,
    input  logic [`DATA_WIDTH-1:0]     rs2_data,
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic                       rf_en,
    input  logic                       opr_a_sel,
    input  logic                       opr_b_sel,
    input  logic [`DATA_WIDTH-1:0]     imm,
    input  logic [`DATA_WIDTH-1:0]     pc,
    input  ex_stage_pkg::aluop_t       aluop,
    input  ex_stage_pkg::cfuop_t       cfuop,
    input  ex_stage_pkg::wb_sel_t      wb_sel,
    input  logic                       wb_rf_en,
    input  logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    input  logic [`DATA_WIDTH-1:0]     wb_data,
    output logic                       mem_valid,
    output logic [`REG_ADDR_WIDTH-1:0] mem_rd,
    output logic                       mem_rf_en,
    output logic [`DATA_WIDTH-1:0]     mem_res,
    output ex_stage_pkg::wb_sel_t      mem_wb_sel,
    output logic [`DATA_WIDTH-1:0]     mem_pc4,
    output logic                       br_valid,
    output logic                       br_taken,
    output logic [`DATA_WIDTH-1:0]     br_target
);

    logic [1:0]             for_a;
    logic [1:0]             for_b;
    logic [`DATA_WIDTH-1:0] mem_fwd;
    logic [`DATA_WIDTH-1:0] for_opr_a;
    logic [`DATA_WIDTH-1:0] for_opr_b;
    logic [`DATA_WIDTH-1:0] opr_a;
    logic [`DATA_WIDTH-1:0] opr_b;
    logic [`DATA_WIDTH-1:0] opr_res;
    logic [`DATA_WIDTH-1:0] pc4;
    logic                   cond_taken;

    fu i_fu (
        .rs1       (rs1      ),
        .rs2       (rs2      ),
        .mem_rf_en (mem_rf_en),
        .mem_rd    (mem_rd   ),
        .wb_rf_en  (wb_rf_en ),
        .wb_rd     (wb_rd    ),
        .for_a     (for_a    ),
        .for_b     (for_b    )
    );

    // A jump in the memory stage writes pc+4, not its target.
    assign mem_fwd = (mem_wb_sel == ex_stage_pkg::wb_pc4) ? mem_pc4 : mem_res;

    always_comb
    begin
        case (for_a)
            2'b01:   for_opr_a = mem_fwd;
            2'b10:   for_opr_a = wb_data;
            default: for_opr_a = rs1_data;
        endcase
        case (for_b)
            2'b01:   for_opr_b = mem_fwd;
            2'b10:   for_opr_b = wb_data;
            default: for_opr_b = rs2_data;
        endcase
    end

    assign opr_a = opr_a_sel ? pc  : for_opr_a;   // auipc and branch targets.
    assign opr_b = opr_b_sel ? imm : for_opr_b;
    assign pc4   = pc + `DATA_WIDTH'(4);

    alu i_alu (
        .aluop      (aluop  ),
        .opr_a      (opr_a  ),
        .opr_b      (opr_b  ),
        .opr_result (opr_res)
    );

    cfu i_cfu (
        .cfuop    (cfuop     ),
        .opr_a    (for_opr_a ),
        .opr_b    (for_opr_b ),
        .br_taken (cond_taken)
    );

    // EX/MEM register.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_valid <= 1'b0;
            mem_rf_en <= 1'b0;
            br_valid  <= 1'b0;
            br_taken  <= 1'b0;
        end
        else
        begin
            mem_valid <= valid;
            mem_rf_en <= valid && rf_en;
            br_valid  <= valid && (cfuop != ex_stage_pkg::cfu_none);
            br_taken  <= valid && cond_taken;
        end
        mem_rd     <= rd;
        mem_res    <= opr_res;
        mem_wb_sel <= wb_sel;
        mem_pc4    <= pc4;
        br_target  <= opr_res;            // pc+imm, or rs1+imm for jalr.
    end

endmodule : ex_stage

// File: logic/reg_file.sv
// Integer register file of the pipeline with x0 held at zero and write-through reads.
`timescale 1ns/10ps
`include "ex_consts.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    input  logic                       wr_en,
    input  logic [`REG_ADDR_WIDTH-1:0] wr_rd,
    input  logic [`DATA_WIDTH-1:0]     wr_data,
    output logic [`DATA_WIDTH-1:0]     rs1_data,
    output logic [`DATA_WIDTH-1:0]     rs2_data
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wr_en && (wr_rd != '0))
        begin
            regs[wr_rd] <= wr_data;           // x0 never written.
        end
    end

    always_comb
    begin
        if (rs1 == '0)
            rs1_data = '0;
        else if (wr_en && (wr_rd == rs1))
            rs1_data = wr_data;               // Same-cycle write bypass.
        else
            rs1_data = regs[rs1];

        if (rs2 == '0)
            rs2_data = '0;
        else if (wr_en && (wr_rd == rs2))
            rs2_data = wr_data;
        else
            rs2_data = regs[rs2];
    end

endmodule : reg_file

// File: logic/ex_pipe.sv
// Top of the execute slice: ID/EX register, register file, execute stage and MEM/WB register.
`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_pipe (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue_valid,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic                       rf_en,
    input  logic                       opr_a_sel,
    input  logic                       opr_b_sel,
    input  logic [`DATA_WIDTH-1:0]     imm,
    input  logic [`DATA_WIDTH-1:0]     pc,
    input  ex_stage_pkg::aluop_t       aluop,
    input  ex_stage_pkg::cfuop_t       cfuop,
    input  ex_stage_pkg::wb_sel_t      wb_sel,
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [`DATA_WIDTH-1:0]     wb_data,
    output logic                       br_valid,
    output logic                       br_taken,
    output logic [`DATA_WIDTH-1:0]     br_target
);

    logic [`DATA_WIDTH-1:0]     rf_rs1_data;
    logic [`DATA_WIDTH-1:0]     rf_rs2_data;

    logic                       ex_valid;
    logic [`REG_ADDR_WIDTH-1:0] ex_rs1;
    logic [`REG_ADDR_WIDTH-1:0] ex_rs2;
    logic [`DATA_WIDTH-1:0]     ex_rs1_data;
    logic [`DATA_WIDTH-1:0]     ex_rs2_data;
    logic [`REG_ADDR_WIDTH-1:0] ex_rd;
    logic                       ex_rf_en;
    logic                       ex_opr_a_sel;
    logic                       ex_opr_b_sel;
    logic [`DATA_WIDTH-1:0]     ex_imm;
    logic [`DATA_WIDTH-1:0]     ex_pc;
    ex_stage_pkg::aluop_t       ex_aluop;
    ex_stage_pkg::cfuop_t       ex_cfuop;
    ex_stage_pkg::wb_sel_t      ex_wb_sel;

    logic                       mem_valid;
    logic [`REG_ADDR_WIDTH-1:0] mem_rd;
    logic                       mem_rf_en;
    logic [`DATA_WIDTH-1:0]     mem_res;
    ex_stage_pkg::wb_sel_t      mem_wb_sel;
    logic [`DATA_WIDTH-1:0]     mem_pc4;

    reg_file i_reg_file (
        .clk      (clk        ),
        .reset    (reset      ),
        .rs1      (rs1        ),
        .rs2      (rs2        ),
        .wr_en    (wb_valid   ),
        .wr_rd    (wb_rd      ),
        .wr_data  (wb_data    ),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    // ID/EX register.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_valid <= 1'b0;
            ex_rf_en <= 1'b0;
        end
        else
        begin
            ex_valid <= issue_valid;
            ex_rf_en <= rf_en;
        end
        ex_rs1       <= rs1;
        ex_rs2       <= rs2;
        ex_rs1_data  <= rf_rs1_data;
        ex_rs2_data  <= rf_rs2_data;
        ex_rd        <= rd;
        ex_opr_a_sel <= opr_a_sel;
        ex_opr_b_sel <= opr_b_sel;
        ex_imm       <= imm;
        ex_pc        <= pc;
        ex_aluop     <= aluop;
        ex_cfuop     <= cfuop;
        ex_wb_sel    <= wb_sel;
    end

    ex_stage i_ex_stage (
        .clk        (clk         ),
        .reset      (reset       ),
        .valid      (ex_valid    ),
        .rs1        (ex_rs1      ),
        .rs2        (ex_rs2      ),
        .rs1_data   (ex_rs1_data ),
        .rs2_data   (ex_rs2_data ),
        .rd         (ex_rd       ),
        .rf_en      (ex_rf_en    ),
        .opr_a_sel  (ex_opr_a_sel),
        .opr_b_sel  (ex_opr_b_sel),
        .imm        (ex_imm      ),
        .pc         (ex_pc       ),
        .aluop      (ex_aluop    ),
        .cfuop      (ex_cfuop    ),
        .wb_sel     (ex_wb_sel   ),
        .wb_rf_en   (wb_valid    ),
        .wb_rd      (wb_rd       ),
        .wb_data    (wb_data     ),
        .mem_valid  (mem_valid   ),
        .mem_rd     (mem_rd      ),
        .mem_rf_en  (mem_rf_en   ),
        .mem_res    (mem_res     ),
        .mem_wb_sel (mem_wb_sel  ),
        .mem_pc4    (mem_pc4     ),
        .br_valid   (br_valid    ),
        .br_taken   (br_taken    ),
        .br_target  (br_target   )
    );

    // MEM/WB register.
    always_ff @(posedge clk)
    begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_valid && mem_rf_en && (mem_rd != '0);
        wb_rd   <= mem_rd;
        wb_data <= (mem_wb_sel == ex_stage_pkg::wb_pc4) ? mem_pc4 : mem_res;  // Link value.
    end

endmodule : ex_pipe

// File: verif/ex_pipe_tb.sv
// Self-checking testbench of the execute slice; compile with list.f, top module ex_pipe_tb.
`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_pipe_tb;

    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_LEN   = 400;

    logic                       clk;
    logic                       reset;
    logic                       issue_valid;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic                       rf_en;
    logic                       opr_a_sel;
    logic                       opr_b_sel;
    logic [`DATA_WIDTH-1:0]     imm;
    logic [`DATA_WIDTH-1:0]     pc;
    ex_stage_pkg::aluop_t       aluop;
    ex_stage_pkg::cfuop_t       cfuop;
    ex_stage_pkg::wb_sel_t      wb_sel;
    logic                       wb_valid;
    logic [`REG_ADDR_WIDTH-1:0] wb_rd;
    logic [`DATA_WIDTH-1:0]     wb_data;
    logic                       br_valid;
    logic                       br_taken;
    logic [`DATA_WIDTH-1:0]     br_target;

    logic [`DATA_WIDTH-1:0]     model_regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0]     seed;
    logic [`DATA_WIDTH-1:0]     pc_next;
    logic [`DATA_WIDTH-1:0]     br_a [4] = '{32'd5, 32'hfffffffd, 32'd4, 32'h80000000};
    logic [`DATA_WIDTH-1:0]     br_b [4] = '{32'd5, 32'd4, 32'hfffffffd, 32'd1};

    logic [`REG_ADDR_WIDTH-1:0] exp_wb_rd [$];
    logic [`DATA_WIDTH-1:0]     exp_wb_data [$];
    int unsigned                exp_wb_time [$];
    logic                       exp_br_taken [$];
    logic [`DATA_WIDTH-1:0]     exp_br_target [$];
    int unsigned                exp_br_time [$];

    int cycles;
    int slots;
    int mismatches;
    int other_errors;

    ex_pipe ex_pipe_i (
        .clk         (clk        ),
        .reset       (reset      ),
        .issue_valid (issue_valid),
        .rs1         (rs1        ),
        .rs2         (rs2        ),
        .rd          (rd         ),
        .rf_en       (rf_en      ),
        .opr_a_sel   (opr_a_sel  ),
        .opr_b_sel   (opr_b_sel  ),
        .imm         (imm        ),
        .pc          (pc         ),
        .aluop       (aluop      ),
        .cfuop       (cfuop      ),
        .wb_sel      (wb_sel     ),
        .wb_valid    (wb_valid   ),
        .wb_rd       (wb_rd      ),
        .wb_data     (wb_data    ),
        .br_valid    (br_valid   ),
        .br_taken    (br_taken   ),
        .br_target   (br_target  )
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] ref_alu(input ex_stage_pkg::aluop_t op,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];
        case (op)
            ex_stage_pkg::alu_add:    r = a + b;
            ex_stage_pkg::alu_sub:    r = a + ~b + 32'd1;
            ex_stage_pkg::alu_sll:    r = a << sh;
            ex_stage_pkg::alu_slt:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ex_stage_pkg::alu_sltu:   r = (a < b) ? 32'd1 : 32'd0;
            ex_stage_pkg::alu_xor:    r = a ^ b;
            ex_stage_pkg::alu_srl:    r = a >> sh;
            ex_stage_pkg::alu_sra:    r = (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'd0);
            ex_stage_pkg::alu_or:     r = a | b;
            ex_stage_pkg::alu_and:    r = a & b;
            ex_stage_pkg::alu_pass_b: r = b;
            default:                  r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic logic ref_taken(input ex_stage_pkg::cfuop_t op,
                                       input logic [31:0] a, input logic [31:0] b);
        case (op)
            ex_stage_pkg::cfu_beq:  return a == b;
            ex_stage_pkg::cfu_bne:  return a != b;
            ex_stage_pkg::cfu_blt:  return $signed(a) < $signed(b);
            ex_stage_pkg::cfu_bge:  return $signed(a) >= $signed(b);
            ex_stage_pkg::cfu_bltu: return a < b;
            ex_stage_pkg::cfu_bgeu: return a >= b;
            ex_stage_pkg::cfu_jump: return 1'b1;
            default:                return 1'b0;
        endcase
    endfunction

    // Sequential execution; t is the drive time, outputs are sampled on falling edges.
    function automatic void model_exec(input logic [4:0] s1, input logic [4:0] s2,
            input logic [4:0] d, input logic en, input logic a_sel, input logic b_sel,
            input logic [31:0] im, input logic [31:0] p, input ex_stage_pkg::aluop_t aop,
            input ex_stage_pkg::cfuop_t cop, input ex_stage_pkg::wb_sel_t ws,
            input int unsigned t);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a   = a_sel ? p : model_regs[s1];
        b   = b_sel ? im : model_regs[s2];
        res = ref_alu(aop, a, b);
        if (cop != ex_stage_pkg::cfu_none)
        begin
            exp_br_taken.push_back(ref_taken(cop, model_regs[s1], model_regs[s2]));
            exp_br_target.push_back(res);
            exp_br_time.push_back(t + 10);        // One cycle after issue.
        end
        if (en && (d != 5'd0))
        begin
            model_regs[d] = (ws == ex_stage_pkg::wb_pc4) ? p + 32'd4 : res;
            exp_wb_rd.push_back(d);
            exp_wb_data.push_back(model_regs[d]);
            exp_wb_time.push_back(t + 14);        // Two cycles after issue.
        end
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic issue(input logic v, input logic [4:0] s1, input logic [4:0] s2,
            input logic [4:0] d, input logic en, input logic a_sel, input logic b_sel,
            input logic [31:0] im, input ex_stage_pkg::aluop_t aop,
            input ex_stage_pkg::cfuop_t cop, input ex_stage_pkg::wb_sel_t ws);
        @(posedge clk);
        issue_valid <= v;
        rs1         <= s1;
        rs2         <= s2;
        rd          <= d;
        rf_en       <= en;
        opr_a_sel   <= a_sel;
        opr_b_sel   <= b_sel;
        imm         <= im;
        pc          <= pc_next;
        aluop       <= aop;
        cfuop       <= cop;
        wb_sel      <= ws;
        if (v)
            model_exec(s1, s2, d, en, a_sel, b_sel, im, pc_next, aop, cop, ws, 32'($time));
        pc_next = pc_next + 32'd4;
        slots++;
    endtask

    // Garbage fields with rf_en and a branch set, all to be ignored.
    task automatic bubble();
        issue(1'b0, 5'(next_rand()), 5'(next_rand()), 5'(next_rand()), 1'b1, 1'b0, 1'b0,
              next_rand(), ex_stage_pkg::alu_add, ex_stage_pkg::cfu_beq, ex_stage_pkg::wb_alu);
    endtask

    task automatic op_reg(input ex_stage_pkg::aluop_t aop, input logic [4:0] d,
                          input logic [4:0] s1, input logic [4:0] s2);
        issue(1'b1, s1, s2, d, 1'b1, 1'b0, 1'b0, 32'd0, aop, ex_stage_pkg::cfu_none,
              ex_stage_pkg::wb_alu);
    endtask

    task automatic op_imm(input ex_stage_pkg::aluop_t aop, input logic [4:0] d,
                          input logic [4:0] s1, input logic [31:0] im);
        issue(1'b1, s1, 5'd0, d, 1'b1, 1'b0, 1'b1, im, aop, ex_stage_pkg::cfu_none,
              ex_stage_pkg::wb_alu);
    endtask

    task automatic branch(input ex_stage_pkg::cfuop_t cop, input logic [4:0] s1,
                          input logic [4:0] s2, input logic [31:0] im);
        issue(1'b1, s1, s2, 5'd0, 1'b0, 1'b1, 1'b1, im, ex_stage_pkg::alu_add, cop,
              ex_stage_pkg::wb_alu);
    endtask

    always @(negedge clk)
    begin
        if (wb_valid === 1'b1)
        begin
            if (exp_wb_rd.size() == 0)
            begin
                other_errors++;
                $display("unexpected writeback to x%0d at %0t ns", wb_rd, $time);
            end
            else
            begin
                check("wb_rd", 32'(wb_rd), 32'(exp_wb_rd.pop_front()));
                check("wb_data", wb_data, exp_wb_data.pop_front());
                check("writeback time", 32'($time), exp_wb_time.pop_front());
            end
        end
        else if ((exp_wb_time.size() != 0) && (exp_wb_time[0] <= 32'($time)))
        begin
            other_errors++;
            $display("writeback to x%0d missing at %0t ns", exp_wb_rd[0], $time);
            void'(exp_wb_rd.pop_front());
            void'(exp_wb_data.pop_front());
            void'(exp_wb_time.pop_front());
        end
        if (br_valid === 1'b1)
        begin
            if (exp_br_taken.size() == 0)
            begin
                other_errors++;
                $display("unexpected branch outcome at %0t ns", $time);
            end
            else
            begin
                check("br_taken", 32'(br_taken), 32'(exp_br_taken.pop_front()));
                check("br_target", br_target, exp_br_target.pop_front());
                check("branch time", 32'($time), exp_br_time.pop_front());
            end
        end
        else if ((exp_br_time.size() != 0) && (exp_br_time[0] <= 32'($time)))
        begin
            other_errors++;
            $display("branch outcome missing at %0t ns", $time);
            void'(exp_br_taken.pop_front());
            void'(exp_br_target.pop_front());
            void'(exp_br_time.pop_front());
        end
    end

    // Limit grows with every issued slot.
    initial
    begin
        cycles = 0;
        while (cycles < RESET_CYCLES + slots + 50)
        begin
            @(posedge clk);
            cycles++;
        end
        other_errors++;
        $display("timeout: pipeline still busy after %0d cycles", cycles);
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [4:0]  d;
        ex_stage_pkg::aluop_t aop;
        seed         = 32'd29406;
        pc_next      = 32'h00001000;
        slots        = 0;
        mismatches   = 0;
        other_errors = 0;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = 32'd0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        rs1         = 5'd0;
        rs2         = 5'd0;
        rd          = 5'd0;
        rf_en       = 1'b0;
        opr_a_sel   = 1'b0;
        opr_b_sel   = 1'b0;
        imm         = 32'd0;
        pc          = 32'd0;
        aluop       = ex_stage_pkg::alu_add;
        cfuop       = ex_stage_pkg::cfu_none;
        wb_sel      = ex_stage_pkg::wb_alu;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        repeat (4) bubble();
        @(negedge clk);
        check("idle wb_valid", 32'(wb_valid), 32'd0);
        check("idle br_valid", 32'(br_valid), 32'd0);
        for (int n = 1; n < `REG_COUNT; n++)
            op_reg(ex_stage_pkg::alu_add, 5'(n), 5'(n), 5'd0);   // All zero after reset.

        for (int n = 1; n < 8; n++)
            op_imm(ex_stage_pkg::alu_add, 5'(n), 5'd0, next_rand());
        for (int op = 0; op < 11; op++)
        begin
            aop = ex_stage_pkg::aluop_t'(4'(op));
            op_reg(aop, 5'(8 + op), 5'(op % 7 + 1), 5'((op + 3) % 7 + 1));
            op_imm(aop, 5'(20 + op), 5'(op % 7 + 1), next_rand());
        end
        issue(1'b1, 5'd0, 5'd0, 5'd9, 1'b1, 1'b0, 1'b1, 32'h12345000,
              ex_stage_pkg::alu_pass_b, ex_stage_pkg::cfu_none, ex_stage_pkg::wb_alu);
        issue(1'b1, 5'd0, 5'd0, 5'd10, 1'b1, 1'b1, 1'b1, 32'h00003000,
              ex_stage_pkg::alu_add, ex_stage_pkg::cfu_none, ex_stage_pkg::wb_alu);

        // Distances one, two and three.
        for (int gap = 0; gap < 3; gap++)
        begin
            repeat (4)
            begin
                op_imm(ex_stage_pkg::alu_add, 5'd11, 5'd11, 32'd3);
                repeat (gap) bubble();
                op_reg(ex_stage_pkg::alu_add, 5'd12, 5'd11, 5'd12);
                repeat (gap) bubble();
            end
        end

        for (int c = 1; c < 7; c++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                op_imm(ex_stage_pkg::alu_add, 5'd1, 5'd0, br_a[k]);
                op_imm(ex_stage_pkg::alu_add, 5'd2, 5'd0, br_b[k]);
                branch(ex_stage_pkg::cfuop_t'(3'(c)), 5'd1, 5'd2, 32'(k * 16 + 8));
            end
        end
        issue(1'b1, 5'd0, 5'd0, 5'd3, 1'b1, 1'b1, 1'b1, 32'h40,
              ex_stage_pkg::alu_add, ex_stage_pkg::cfu_jump, ex_stage_pkg::wb_pc4);
        op_reg(ex_stage_pkg::alu_add, 5'd4, 5'd3, 5'd0);
        issue(1'b1, 5'd4, 5'd0, 5'd5, 1'b1, 1'b0, 1'b1, 32'h8,
              ex_stage_pkg::alu_add, ex_stage_pkg::cfu_jump, ex_stage_pkg::wb_pc4);
        op_reg(ex_stage_pkg::alu_add, 5'd6, 5'd5, 5'd0);

        op_imm(ex_stage_pkg::alu_add, 5'd0, 5'd4, 32'd7);
        op_reg(ex_stage_pkg::alu_add, 5'd6, 5'd0, 5'd0);
        op_imm(ex_stage_pkg::alu_or, 5'd7, 5'd0, 32'd5);

        for (int n = 0; n < RANDOM_LEN; n++)
        begin
            r   = next_rand();
            s1  = 5'(r[10:8]);                    // Few registers, many hazards.
            s2  = 5'(r[13:11]);
            d   = 5'(r[16:14]);
            aop = ex_stage_pkg::aluop_t'(4'(r[31:24] % 8'd11));
            if (r[3:0] < 4'd3)
                bubble();
            else
                case (r[6:4])
                    3'd0, 3'd1: op_reg(aop, d, s1, s2);
                    3'd2, 3'd3: op_imm(aop, d, s1, next_rand());
                    3'd4: issue(1'b1, s1, s2, d, 1'b1, r[17], 1'b1, next_rand() & 32'hfffff000,
                                r[17] ? ex_stage_pkg::alu_add : ex_stage_pkg::alu_pass_b,
                                ex_stage_pkg::cfu_none, ex_stage_pkg::wb_alu);
                    3'd5: branch(ex_stage_pkg::cfuop_t'(3'(r[23:21] % 3'd6 + 3'd1)), s1, s2,
                                 next_rand());
                    3'd6: issue(1'b1, s1, s2, d, 1'b1, r[17], 1'b1, next_rand(),
                                ex_stage_pkg::alu_add, ex_stage_pkg::cfu_jump,
                                ex_stage_pkg::wb_pc4);
                    default: issue(1'b1, s1, s2, d, 1'b0, 1'b0, 1'b0, 32'd0, aop,
                                   ex_stage_pkg::cfu_none, ex_stage_pkg::wb_alu);
                endcase
        end
        bubble();

        while ((exp_wb_rd.size() != 0) || (exp_br_taken.size() != 0))
            @(posedge clk);
        repeat (5) @(posedge clk);
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if ((mismatches == 0) && (other_errors == 0))
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule : ex_pipe_tb

// File: list.f
+incdir+logic
logic/ex_stage_pkg.sv
logic/fu.sv
logic/alu.sv
logic/cfu.sv
logic/ex_stage.sv
logic/reg_file.sv
logic/ex_pipe.sv
verif/ex_pipe_tb.sv

// File: run.sh
#!/bin/sh
# Builds the execute slice testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 -f list.f --top-module ex_pipe_tb -Mdir obj_dir
then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vex_pipe_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
